// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Instruction and address width.
    localparam int unsigned XLEN = 32;

    // Register byte offsets.
    localparam logic [3:0] CSR_CTRL    = 4'h0;
    localparam logic [3:0] CSR_BOOT_PC = 4'h4;
    localparam logic [3:0] CSR_RETIRED = 4'h8;
    localparam logic [3:0] CSR_STATUS  = 4'hC;

    // Halfword view of one word, low half first in memory order.
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } halfword_pair_t;

    // One buffer word, read as a full instruction or as two halfwords.
    typedef union packed {
        logic [XLEN-1:0] word;
        halfword_pair_t  half;
    } instr_word_u;

    // Control from the register block.
    typedef struct packed {
        logic            enable;
        logic            flush;
        logic [XLEN-1:0] boot_pc;
    } fetch_ctrl_t;

    // Bundle request toward instruction memory.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
    } mem_req_t;

    // Output stream payload.
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            compressed;
    } fetch_out_t;

    // AXI4-Lite, master to slave.
    typedef struct packed {
        logic            awvalid;
        logic [XLEN-1:0] awaddr;
        logic            wvalid;
        logic [XLEN-1:0] wdata;
        logic [3:0]      wstrb;
        logic            bready;
        logic            arvalid;
        logic [XLEN-1:0] araddr;
        logic            rready;
    } axil_req_t;

    // AXI4-Lite, slave to master.
    typedef struct packed {
        logic            awready;
        logic            wready;
        logic            bvalid;
        logic [1:0]      bresp;
        logic            arready;
        logic            rvalid;
        logic [XLEN-1:0] rdata;
        logic [1:0]      rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// ==== hw/fetch_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_csr (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  fetch_pkg::axil_req_t   axil_req_i,
    output fetch_pkg::axil_rsp_t   axil_rsp_o,
    output fetch_pkg::fetch_ctrl_t ctrl_o,
    input  logic                   retire_i,
    input  logic                   buffer_empty_i,
    input  logic                   req_pending_i
);

    logic                       awready_q;
    logic                       bvalid_q;
    logic                       arready_q;
    logic                       rvalid_q;
    logic [fetch_pkg::XLEN-1:0] rdata_q;
    logic                       enable_q;
    logic                       flush_q;
    logic [fetch_pkg::XLEN-1:0] boot_pc_q;
    logic [fetch_pkg::XLEN-1:0] retired_q;
    logic                       wr_accept;
    logic                       rd_accept;
    logic [3:0]                 wr_offset;
    logic [3:0]                 rd_offset;
    logic [fetch_pkg::XLEN-1:0] rd_value;

    // Only the low nibble selects a register.
    assign wr_offset = axil_req_i.awaddr[3:0];
    assign rd_offset = axil_req_i.araddr[3:0];

    // Write needs both valids and our ready pair.
    assign wr_accept = axil_req_i.awvalid && axil_req_i.wvalid && awready_q;
    assign rd_accept = axil_req_i.arvalid && arready_q;

    // Channel handshakes.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            // Ready pulses one cycle after both valids and never while a response waits.
            awready_q <= !awready_q && !bvalid_q && axil_req_i.awvalid && axil_req_i.wvalid;
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            arready_q <= !arready_q && !rvalid_q && axil_req_i.arvalid;
            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Control and boot address.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q  <= 1'b0;
            flush_q   <= 1'b0;
            boot_pc_q <= '0;
        end else begin
            flush_q <= 1'b0;
            if (wr_accept && wr_offset == fetch_pkg::CSR_CTRL && axil_req_i.wstrb[0]) begin
                enable_q <= axil_req_i.wdata[0];
                // Restart pulse on a flush write or on enable rising.
                flush_q  <= axil_req_i.wdata[1] || (axil_req_i.wdata[0] && !enable_q);
            end
            if (wr_accept && wr_offset == fetch_pkg::CSR_BOOT_PC) begin
                for (int b = 0; b < 4; b++) begin
                    if (axil_req_i.wstrb[b]) begin
                        boot_pc_q[8*b +: 8] <= axil_req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Retired count restarts with the stream.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_q) begin
            retired_q <= '0;
        end else if (retire_i) begin
            retired_q <= retired_q + 1'b1;
        end
    end

    // Read decode.
    always_comb begin
        case (rd_offset)
            fetch_pkg::CSR_CTRL:    rd_value = {31'b0, enable_q};
            fetch_pkg::CSR_BOOT_PC: rd_value = boot_pc_q;
            fetch_pkg::CSR_RETIRED: rd_value = retired_q;
            fetch_pkg::CSR_STATUS:  rd_value = {30'b0, req_pending_i, buffer_empty_i};
            default:                rd_value = '0;
        endcase
    end

    // Read data held until rready.
    always_ff @(posedge clk_i) begin
        if (rd_accept) begin
            rdata_q <= rd_value;
        end
    end

    assign axil_rsp_o = '{
        awready: awready_q,
        wready:  awready_q,
        bvalid:  bvalid_q,
        bresp:   2'b00,
        arready: arready_q,
        rvalid:  rvalid_q,
        rdata:   rdata_q,
        rresp:   2'b00
    };

    assign ctrl_o = '{enable: enable_q, flush: flush_q, boot_pc: boot_pc_q};

    // Responses only follow handshakes seen on the ports.
    bvalid_needs_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(axil_rsp_o.bvalid) |->
            $past(axil_req_i.awvalid && axil_req_i.wvalid &&
                  axil_rsp_o.awready && axil_rsp_o.wready));
    rvalid_needs_read: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(axil_rsp_o.rvalid) |-> $past(axil_req_i.arvalid && axil_rsp_o.arready));

endmodule

`default_nettype wire

// ==== hw/bundle_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module bundle_fetcher #(
    parameter int IBUFFER_WORDS = 4
) (
    input  logic                                             clk_i,
    input  logic                                             rst_n_i,
    input  fetch_pkg::fetch_ctrl_t                           ctrl_i,
    input  logic                                             buffer_request_i,
    input  logic                                             buffer_empty_i,
    output fetch_pkg::mem_req_t                              mem_req_o,
    input  logic                                             mem_rsp_valid_i,
    input  logic [IBUFFER_WORDS-1:0][fetch_pkg::XLEN-1:0]    mem_rsp_bundle_i,
    output fetch_pkg::instr_word_u [IBUFFER_WORDS-1:0]       bundle_o,
    output logic                                             load_o,
    output logic                                             req_pending_o
);

    localparam logic [fetch_pkg::XLEN-1:0] BUNDLE_BYTES = 4 * IBUFFER_WORDS;

    fetch_pkg::mem_req_t                        req_q;
    logic [fetch_pkg::XLEN-1:0]                 next_addr_q;
    fetch_pkg::instr_word_u [IBUFFER_WORDS-1:0] staged_q;
    logic                                       staged_valid_q;
    logic                                       drop_q;
    logic                                       rsp_taken;
    logic                                       issue;
    logic [fetch_pkg::XLEN-1:0]                 fetch_base;
    logic [fetch_pkg::XLEN-1:0]                 fetch_addr;

    assign rsp_taken = req_q.valid && mem_rsp_valid_i;

    // A restart fetches straight from the boot PC.
    assign fetch_base = ctrl_i.flush ? ctrl_i.boot_pc : next_addr_q;
    assign fetch_addr = fetch_base & ~(BUNDLE_BYTES - 1'b1);

    // One request in flight, and none while a bundle waits in the stage.
    assign issue = ctrl_i.enable && !req_q.valid &&
                   (ctrl_i.flush || (buffer_request_i && !staged_valid_q));

    // Stage hands over only into an empty buffer.
    assign load_o = staged_valid_q && buffer_empty_i && !ctrl_i.flush;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q          <= '0;
            next_addr_q    <= '0;
            staged_valid_q <= 1'b0;
            drop_q         <= 1'b0;
        end else begin
            if (rsp_taken) begin
                req_q.valid <= 1'b0;
            end
            if (ctrl_i.flush) begin
                staged_valid_q <= 1'b0;
                // Response still owed for the old stream.
                drop_q         <= req_q.valid && !mem_rsp_valid_i;
                next_addr_q    <= ctrl_i.boot_pc;
            end else if (rsp_taken) begin
                staged_valid_q <= !drop_q;
                drop_q         <= 1'b0;
            end else if (load_o) begin
                staged_valid_q <= 1'b0;
            end
            if (issue) begin
                req_q.valid <= 1'b1;
                req_q.addr  <= fetch_addr;
                next_addr_q <= fetch_addr + BUNDLE_BYTES;
            end
        end
    end

    // Bundle payload.
    always_ff @(posedge clk_i) begin
        if (rsp_taken) begin
            staged_q <= mem_rsp_bundle_i;
        end
    end

    assign mem_req_o     = req_q;
    assign bundle_o      = staged_q;
    assign req_pending_o = req_q.valid;

    // Held request keeps its address.
    req_addr_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_q.valid && !mem_rsp_valid_i |=> req_q.valid && $stable(req_q.addr));

endmodule

`default_nettype wire

// ==== hw/instruction_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_buffer #(
    parameter int IBUFFER_WORDS = 4,
    parameter int REQUEST_LIMIT = 2
) (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,
    input  logic                                       stall_i,
    input  logic                                       flush_i,
    input  logic                                       load_i,
    input  logic                                       compressed_i,
    input  fetch_pkg::instr_word_u [IBUFFER_WORDS-1:0] instr_bundle_i,
    input  logic [$clog2(2 * IBUFFER_WORDS):0]         bundle_size_i,
    output fetch_pkg::instr_word_u                     fetched_instr_o,
    output logic                                       instr_request_o,
    output logic                                       buffer_empty_o
);

    // Size in halfwords.
    logic [$clog2(2 * IBUFFER_WORDS):0]         size_q;
    fetch_pkg::instr_word_u [IBUFFER_WORDS-1:0] buf_q;
    logic                                       consume;

    assign consume = !stall_i && !buffer_empty_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            size_q <= '0;
        end else if (load_i) begin
            size_q <= bundle_size_i;
        end else if (consume) begin
            if (compressed_i) begin
                size_q <= size_q - 1'b1;
            end else begin
                size_q <= size_q - 2'd2;
            end
        end
    end

    // Word 0 is the head; contents move down by one or two halfwords.
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            buf_q <= instr_bundle_i;
        end else if (consume) begin
            for (int i = 0; i < IBUFFER_WORDS - 1; i++) begin
                if (compressed_i) begin
                    buf_q[i].half.lo <= buf_q[i].half.hi;
                    buf_q[i].half.hi <= buf_q[i + 1].half.lo;
                end else begin
                    buf_q[i] <= buf_q[i + 1];
                end
            end
            // Top word fills with zeros.
            if (compressed_i) begin
                buf_q[IBUFFER_WORDS-1].half.lo <= buf_q[IBUFFER_WORDS-1].half.hi;
                buf_q[IBUFFER_WORDS-1].half.hi <= '0;
            end else begin
                buf_q[IBUFFER_WORDS-1] <= '0;
            end
        end
    end

    assign fetched_instr_o = buf_q[0];
    assign buffer_empty_o  = (size_q == '0);
    assign instr_request_o = (size_q <= REQUEST_LIMIT);

    // Fetcher refills only into an empty buffer.
    load_when_empty: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) load_i |-> buffer_empty_o);
    // A full instruction never runs past the end of the bundle.
    no_underflow: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        consume && !compressed_i && !load_i && !flush_i |-> size_q >= 2);

endmodule

`default_nettype wire

// ==== hw/instr_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_aligner (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  fetch_pkg::fetch_ctrl_t ctrl_i,
    input  fetch_pkg::instr_word_u head_i,
    input  logic                   buffer_empty_i,
    output logic                   stall_o,
    output logic                   compressed_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output fetch_pkg::fetch_out_t  out_o,
    output logic                   retire_o
);

    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic                       compressed;
    logic                       handshake;

    // RVC when the opcode quadrant is not 2'b11.
    assign compressed = (head_i.half.lo[1:0] != 2'b11);

    assign out_valid_o = ctrl_i.enable && !buffer_empty_i;
    assign handshake   = out_valid_o && out_ready_i;

    // PC restarts with the stream.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (ctrl_i.flush) begin
            pc_q <= ctrl_i.boot_pc;
        end else if (handshake) begin
            pc_q <= pc_q + (compressed ? 32'd2 : 32'd4);
        end
    end

    // Compressed instructions leave zero-extended.
    assign out_o = '{
        pc:         pc_q,
        instr:      compressed ? {16'b0, head_i.half.lo} : head_i.word,
        compressed: compressed
    };

    // Buffer holds until the consumer takes the head.
    assign stall_o      = !handshake;
    assign compressed_o = compressed;
    assign retire_o     = handshake;

    // Held data stays put across buffer and PC.
    out_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i && !ctrl_i.flush |=> $stable(out_o));

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int IBUFFER_WORDS = 4,
    parameter int REQUEST_LIMIT = 2
) (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  fetch_pkg::axil_req_t                          axil_req_i,
    output fetch_pkg::axil_rsp_t                          axil_rsp_o,
    output fetch_pkg::mem_req_t                           mem_req_o,
    input  logic                                          mem_rsp_valid_i,
    input  logic [IBUFFER_WORDS-1:0][fetch_pkg::XLEN-1:0] mem_rsp_bundle_i,
    output logic                                          out_valid_o,
    input  logic                                          out_ready_i,
    output fetch_pkg::fetch_out_t                         out_o
);

    localparam int SIZE_W = $clog2(2 * IBUFFER_WORDS) + 1;

    // Every bundle is full, in halfwords.
    localparam logic [SIZE_W-1:0] BUNDLE_HALVES = SIZE_W'(2 * IBUFFER_WORDS);

    fetch_pkg::fetch_ctrl_t                     ctrl;
    fetch_pkg::instr_word_u [IBUFFER_WORDS-1:0] bundle;
    fetch_pkg::instr_word_u                     head;
    logic                                       buffer_request;
    logic                                       buffer_empty;
    logic                                       load;
    logic                                       req_pending;
    logic                                       stall;
    logic                                       compressed;
    logic                                       retire;

    fetch_csr csr0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .axil_req_i     (axil_req_i),
        .axil_rsp_o     (axil_rsp_o),
        .ctrl_o         (ctrl),
        .retire_i       (retire),
        .buffer_empty_i (buffer_empty),
        .req_pending_i  (req_pending)
    );

    bundle_fetcher #(.IBUFFER_WORDS(IBUFFER_WORDS)) fetcher0 (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .ctrl_i           (ctrl),
        .buffer_request_i (buffer_request),
        .buffer_empty_i   (buffer_empty),
        .mem_req_o        (mem_req_o),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_bundle_i (mem_rsp_bundle_i),
        .bundle_o         (bundle),
        .load_o           (load),
        .req_pending_o    (req_pending)
    );

    instruction_buffer #(
        .IBUFFER_WORDS (IBUFFER_WORDS),
        .REQUEST_LIMIT (REQUEST_LIMIT)
    ) buffer0 (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall),
        .flush_i         (ctrl.flush),
        .load_i          (load),
        .compressed_i    (compressed),
        .instr_bundle_i  (bundle),
        .bundle_size_i   (BUNDLE_HALVES),
        .fetched_instr_o (head),
        .instr_request_o (buffer_request),
        .buffer_empty_o  (buffer_empty)
    );

    instr_aligner aligner0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ctrl_i         (ctrl),
        .head_i         (head),
        .buffer_empty_i (buffer_empty),
        .stall_o        (stall),
        .compressed_o   (compressed),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_o          (out_o),
        .retire_o       (retire)
    );

endmodule

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int IBUFFER_WORDS = 4;
    localparam int REQUEST_LIMIT = 2;
    localparam int MEM_WORDS     = 256;

    logic                               clk;
    logic                               rst_n;
    fetch_pkg::axil_req_t               axil_req;
    fetch_pkg::axil_rsp_t               axil_rsp;
    fetch_pkg::mem_req_t                mem_req;
    logic                               mem_rsp_valid;
    logic [IBUFFER_WORDS-1:0][31:0]     mem_rsp_bundle;
    logic                               out_valid;
    logic                               out_ready;
    fetch_pkg::fetch_out_t              out;
    logic [31:0]                        mem [MEM_WORDS];
    fetch_pkg::fetch_out_t              expect_q[$];
    fetch_pkg::fetch_out_t              stream_q[$];
    fetch_pkg::fetch_out_t              saved_q[$];
    fetch_pkg::fetch_out_t              held_out;
    logic [31:0]                        lfsr;
    logic [31:0]                        mem_addr;
    logic                               ready_random;
    logic                               latency_random;
    logic                               mem_busy;
    logic                               held;
    int                                 mem_delay;
    string                              test_name;
    int                                 test_checks;
    int                                 test_errors;
    int                                 tests_passed;
    int                                 tests_failed;
    int                                 total_records;

    fetch_top #(
        .IBUFFER_WORDS (IBUFFER_WORDS),
        .REQUEST_LIMIT (REQUEST_LIMIT)
    ) dut0 (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .axil_req_i       (axil_req),
        .axil_rsp_o       (axil_rsp),
        .mem_req_o        (mem_req),
        .mem_rsp_valid_i  (mem_rsp_valid),
        .mem_rsp_bundle_i (mem_rsp_bundle),
        .out_valid_o      (out_valid),
        .out_ready_i      (out_ready),
        .out_o            (out)
    );

    // 40 ns clock.
    always #20 clk = ~clk;

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit taken.
    task automatic draw_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        assert (actual === expected) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // Memory answers 1 to 4 cycles after a new request shows up.
    task automatic serve_memory();
        logic [3:0] bits;
        bits = '0;
        if (mem_rsp_valid) begin
            mem_rsp_valid = 1'b0;
            mem_busy      = 1'b0;
        end else if (mem_req.valid && !mem_busy) begin
            mem_busy = 1'b1;
            mem_addr = mem_req.addr;
            if (latency_random) begin
                draw_bits(2, bits);
            end
            mem_delay = 1 + bits;
        end else if (mem_busy) begin
            // Held request must keep valid and address.
            assert (mem_req.valid && mem_req.addr == mem_addr) else begin
                $display("%s: memory request changed before its response came back", test_name);
                test_errors++;
            end
            mem_delay--;
            if (mem_delay == 0) begin
                for (int w = 0; w < IBUFFER_WORDS; w++) begin
                    mem_rsp_bundle[w] = mem[((mem_addr >> 2) + w) % MEM_WORDS];
                end
                mem_rsp_valid = 1'b1;
            end
        end
    endtask

    // Ready only while records are owed, so nothing extra is taken.
    task automatic drive_stream();
        logic [3:0]            bits;
        fetch_pkg::fetch_out_t exp;
        bits = 4'hf;
        if (held) begin
            assert (out_valid && out == held_out) else begin
                $display("%s: output changed while ready was low", test_name);
                test_errors++;
            end
        end
        if (ready_random) begin
            draw_bits(1, bits);
        end
        out_ready = (expect_q.size() != 0) && bits[0];
        held      = out_valid && !out_ready && (expect_q.size() != 0);
        held_out  = out;
        // Output is stable here, so the next rising edge takes it.
        if (out_valid && out_ready) begin
            exp = expect_q.pop_front();
            check_value("pc", exp.pc, out.pc);
            check_value("instr", exp.instr, out.instr);
            check_value("compressed", 32'(exp.compressed), 32'(out.compressed));
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            serve_memory();
            drive_stream();
        end
    end

    task automatic axil_write(input logic [31:0] offset, input logic [31:0] data);
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = offset;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        test_checks++;
        assert (axil_rsp.wready) else begin
            $display("%s: wready did not rise together with awready", test_name);
            test_errors++;
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        test_checks++;
        assert (axil_rsp.bvalid && axil_rsp.bresp == 2'b00) else begin
            $display("%s: write response missing or not OKAY", test_name);
            test_errors++;
        end
        @(negedge clk);
        axil_req.bready = 1'b0;
        assert (!axil_rsp.bvalid) else begin
            $display("%s: write response repeated", test_name);
            test_errors++;
        end
        @(posedge clk);
    endtask

    task automatic axil_read(input logic [31:0] offset, output logic [31:0] data);
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = offset;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        data             = axil_rsp.rdata;
        test_checks++;
        assert (axil_rsp.rvalid && axil_rsp.rresp == 2'b00) else begin
            $display("%s: read response missing or not OKAY", test_name);
            test_errors++;
        end
        @(negedge clk);
        axil_req.rready = 1'b0;
        assert (!axil_rsp.rvalid) else begin
            $display("%s: read response repeated", test_name);
            test_errors++;
        end
        @(posedge clk);
    endtask

    // Reads until the value shows up, at most 20 tries.
    task automatic poll_register(input logic [31:0] offset, input logic [31:0] expected);
        logic [31:0] got;
        int          tries;
        got   = ~expected;
        tries = 0;
        while (got !== expected && tries < 20) begin
            axil_read(offset, got);
            tries++;
        end
        check_value("poll", expected, got);
    endtask

    task automatic wait_drained();
        while (expect_q.size() != 0) @(posedge clk);
    endtask

    // Closes the running test and keeps its stream for a replay.
    task automatic finish_test();
        wait_drained();
        if (test_name != "" || test_errors != 0) begin
            if (test_errors == 0) begin
                tests_passed++;
            end else begin
                tests_failed++;
            end
            $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        end
        if (stream_q.size() != 0) begin
            saved_q = stream_q;
        end
        stream_q.delete();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic queue_record(input fetch_pkg::fetch_out_t rec);
        expect_q.push_back(rec);
        stream_q.push_back(rec);
        total_records++;
    endtask

    initial begin
        int                    fd;
        int                    code;
        int                    kind;
        string                 line;
        logic [31:0]           a;
        logic [31:0]           d [4];
        logic [31:0]           got;
        fetch_pkg::fetch_out_t rec;
        clk            = 1'b0;
        rst_n          = 1'b0;
        axil_req       = '0;
        mem_rsp_valid  = 1'b0;
        mem_rsp_bundle = '0;
        out_ready      = 1'b0;
        lfsr           = 32'hc730;
        ready_random   = 1'b0;
        latency_random = 1'b0;
        mem_busy       = 1'b0;
        held           = 1'b0;
        test_name      = "";
        total_records  = 0;
        // Unused words carry their own index.
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {~i[15:0], i[15:0]};
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        fd = $fopen("dv/fetch_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/fetch_trace.txt");
            tests_failed++;
        end
        while (fd != 0 && $fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": code = $fgets(line, fd);
                "M": begin
                    code = $fscanf(fd, "%h %h %h %h %h", a, d[0], d[1], d[2], d[3]);
                    for (int w = 0; w < 4; w++) begin
                        mem[((a >> 2) + w) % MEM_WORDS] = d[w];
                    end
                end
                "T": begin
                    finish_test();
                    code = $fscanf(fd, "%s", test_name);
                end
                "C": code = $fscanf(fd, "%h %h", ready_random, latency_random);
                "W": begin
                    code = $fscanf(fd, "%h %h", a, d[0]);
                    wait_drained();
                    axil_write(a, d[0]);
                end
                "R", "P": begin
                    code = $fscanf(fd, "%h %h", a, d[0]);
                    wait_drained();
                    if (kind == "R") begin
                        axil_read(a, got);
                        check_value("register", d[0], got);
                    end else begin
                        poll_register(a, d[0]);
                    end
                end
                "E": begin
                    code = $fscanf(fd, "%h %h %h", a, d[0], d[1]);
                    rec  = '{pc: a, instr: d[0], compressed: d[1][0]};
                    queue_record(rec);
                end
                "A": begin
                    foreach (saved_q[i]) begin
                        queue_record(saved_q[i]);
                    end
                end
                default: begin
                    $display("unknown trace line kind %c", kind);
                    test_errors++;
                end
            endcase
        end
        finish_test();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Budget grows with each queued record.
    initial begin
        int cycles;
        cycles = 0;
        while (cycles <= 1000 + 40 * total_records) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog expired after %0d cycles, %0d records still owed",
                 cycles, expect_q.size());
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/fetch_pkg.sv
hw/fetch_csr.sv
hw/bundle_fetcher.sv
hw/instruction_buffer.sv
hw/instr_aligner.sv
hw/fetch_top.sv
dv/fetch_tb.sv

// ==== dv/fetch_trace.txt ====
# M byte_addr w0 w1 w2 w3 | T test | C ready_random latency_random | A replay last stream
# W offset data | R offset expected | P offset expected (poll) | E pc instr compressed
M 00000100 00500093 05054505 00a08133 00018082
M 00000110 85934505 050500c5 00208067 45058082
M 00000200 80824505 00a08133 00500093 00010505
T register_access
C 0 0
R 0000000c 00000001
W 00000004 00000100
R 00000004 00000100
W 00000000 00000002
R 00000000 00000000
W 00000008 00000055
R 00000008 00000000
T mixed_stream
W 00000000 00000001
E 00000100 00500093 0
E 00000104 00004505 1
E 00000106 00000505 1
E 00000108 00a08133 0
E 0000010c 00008082 1
E 0000010e 00000001 1
E 00000110 00004505 1
E 00000112 00c58593 0
E 00000116 00000505 1
E 00000118 00208067 0
E 0000011c 00008082 1
E 0000011e 00004505 1
T back_pressure
C 1 0
W 00000000 00000003
A
T mem_latency
C 0 1
W 00000000 00000003
A
T flush_restart
C 1 1
W 00000004 00000200
W 00000000 00000003
E 00000200 00004505 1
E 00000202 00008082 1
E 00000204 00a08133 0
E 00000208 00500093 0
E 0000020c 00000505 1
E 0000020e 00000001 1
R 00000008 00000006
T status_drain
W 00000000 00000000
R 00000008 00000006
W 00000000 00000002
P 0000000c 00000001
